// ==== common/axi_pkg.sv ====
package axi_pkg;

    // field widths of the AXI4 channels used here.
    localparam int AXI_ID_W    = 4;
    localparam int AXI_LEN_W   = 8;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;
    localparam int AXI_RESP_W  = 2;

    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'd1;

    localparam logic [AXI_RESP_W-1:0] AXI_RESP_OKAY   = 2'd0;
    localparam logic [AXI_RESP_W-1:0] AXI_RESP_SLVERR = 2'd2;

    localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_WORD = 3'd2;  // four bytes per beat.

endpackage

// ==== common/mem_pkg.sv ====
package mem_pkg;

    localparam int ADDR_W = 32;         // byte address.
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // the sram holds 1 KiB of words.
    localparam int MEM_WORDS  = 256;
    localparam int LINE_BEATS = 4;      // words per instruction line.

    // axi ids, so a response can be traced back to its master.
    localparam int IFU_ID = 1;
    localparam int LSU_ID = 2;

endpackage

// ==== arbiter/axi_arbiter.sv ====
`timescale 1ns/1ns

module axi_arbiter (
    input  logic                              clock,
    input  logic                              rst,
    input  logic [mem_pkg::ADDR_W-1:0]        ifu_araddr, lsu_araddr, lsu_awaddr,
    input  logic                              ifu_arvalid, ifu_rready,
    input  logic [axi_pkg::AXI_ID_W-1:0]      ifu_arid, lsu_arid, lsu_awid,
    input  logic [axi_pkg::AXI_LEN_W-1:0]     ifu_arlen, lsu_arlen, lsu_awlen,
    input  logic [axi_pkg::AXI_SIZE_W-1:0]    ifu_arsize, lsu_arsize, lsu_awsize,
    input  logic [axi_pkg::AXI_BURST_W-1:0]   ifu_arburst, lsu_arburst, lsu_awburst,
    output logic                              ifu_arready, ifu_rvalid, ifu_rlast,
    output logic [mem_pkg::DATA_W-1:0]        ifu_rdata, lsu_rdata,
    output logic [axi_pkg::AXI_RESP_W-1:0]    ifu_rresp, lsu_rresp, lsu_bresp,
    output logic [axi_pkg::AXI_ID_W-1:0]      ifu_rid, lsu_rid, lsu_bid,
    input  logic                              lsu_arvalid, lsu_rready, lsu_awvalid,
    input  logic [mem_pkg::DATA_W-1:0]        lsu_wdata,
    input  logic [mem_pkg::STRB_W-1:0]        lsu_wstrb,
    input  logic                              lsu_wvalid, lsu_wlast, lsu_bready,
    output logic                              lsu_arready, lsu_rvalid, lsu_rlast,
    output logic                              lsu_awready, lsu_wready, lsu_bvalid,
    output logic                              awvalid, wvalid, wlast, bready,
    output logic                              arvalid, rready,
    output logic [mem_pkg::ADDR_W-1:0]        awaddr, araddr,
    output logic [axi_pkg::AXI_ID_W-1:0]      awid, arid,
    output logic [axi_pkg::AXI_LEN_W-1:0]     awlen, arlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0]    awsize, arsize,
    output logic [axi_pkg::AXI_BURST_W-1:0]   awburst, arburst,
    output logic [mem_pkg::DATA_W-1:0]        wdata,
    output logic [mem_pkg::STRB_W-1:0]        wstrb,
    input  logic                              awready, wready, bvalid,
    input  logic                              arready, rvalid, rlast,
    input  logic [axi_pkg::AXI_RESP_W-1:0]    bresp, rresp,
    input  logic [axi_pkg::AXI_ID_W-1:0]      bid, rid,
    input  logic [mem_pkg::DATA_W-1:0]        rdata
);
    import axi_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_IFU, S_LSU} grant_t;

    grant_t state;
    logic   g_ifu;
    logic   g_lsu;
    logic   ifu_pend;
    logic   lsu_pend;
    logic   last_hs;

    assign ifu_pend = ifu_arvalid;
    assign lsu_pend = lsu_awvalid || lsu_arvalid;
    assign g_ifu    = (state == S_IFU);
    assign g_lsu    = (state == S_LSU);

    // the final response of the granted transaction releases the bus.
    assign last_hs = (rvalid && rready && rlast) || (bvalid && bready);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (lsu_pend) begin
                        state <= S_LSU;         // load/store goes first on a tie.
                    end else if (ifu_pend) begin
                        state <= S_IFU;
                    end
                end
                S_IFU: if (last_hs) state <= lsu_pend ? S_LSU : S_IDLE;
                S_LSU: if (last_hs) state <= ifu_pend ? S_IFU : S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // read address and read data follow whichever side holds the grant.
    assign arvalid = g_ifu ? ifu_arvalid : (g_lsu && lsu_arvalid);
    assign araddr  = g_ifu ? ifu_araddr  : (g_lsu ? lsu_araddr  : '0);
    assign arid    = g_ifu ? ifu_arid    : (g_lsu ? lsu_arid    : '0);
    assign arlen   = g_ifu ? ifu_arlen   : (g_lsu ? lsu_arlen   : '0);
    assign arsize  = g_ifu ? ifu_arsize  : (g_lsu ? lsu_arsize  : '0);
    assign arburst = g_ifu ? ifu_arburst : (g_lsu ? lsu_arburst : '0);
    assign rready  = g_ifu ? ifu_rready  : (g_lsu && lsu_rready);

    assign ifu_arready = g_ifu && arready;
    assign ifu_rvalid  = g_ifu && rvalid;
    assign ifu_rlast   = g_ifu && rlast;
    assign ifu_rdata   = g_ifu ? rdata : '0;
    assign ifu_rresp   = g_ifu ? rresp : '0;
    assign ifu_rid     = g_ifu ? rid   : '0;

    assign lsu_arready = g_lsu && arready;
    assign lsu_rvalid  = g_lsu && rvalid;
    assign lsu_rlast   = g_lsu && rlast;
    assign lsu_rdata   = g_lsu ? rdata : '0;
    assign lsu_rresp   = g_lsu ? rresp : '0;
    assign lsu_rid     = g_lsu ? rid   : '0;

    // only the load/store side ever writes.
    assign awvalid = g_lsu && lsu_awvalid;
    assign awaddr  = g_lsu ? lsu_awaddr  : '0;
    assign awid    = g_lsu ? lsu_awid    : '0;
    assign awlen   = g_lsu ? lsu_awlen   : '0;
    assign awsize  = g_lsu ? lsu_awsize  : '0;
    assign awburst = g_lsu ? lsu_awburst : '0;
    assign wvalid  = g_lsu && lsu_wvalid;
    assign wdata   = g_lsu ? lsu_wdata : '0;
    assign wstrb   = g_lsu ? lsu_wstrb : '0;
    assign wlast   = g_lsu && lsu_wlast;
    assign bready  = g_lsu && lsu_bready;

    assign lsu_awready = g_lsu && awready;
    assign lsu_wready  = g_lsu && wready;
    assign lsu_bvalid  = g_lsu && bvalid;
    assign lsu_bresp   = g_lsu ? bresp : '0;
    assign lsu_bid     = g_lsu ? bid   : '0;

    // nothing is requested or answered while no master holds the bus.
    a_idle_quiet: assert property (@(posedge clock) disable iff (rst)
        (state == S_IDLE) |-> (!arvalid && !awvalid && !rvalid && !bvalid));

    // a granted master keeps the bus until the sram has finished its transaction.
    a_grant_hold: assert property (@(posedge clock) disable iff (rst)
        $changed(state) |-> awready);

endmodule

// ==== design/ifu_fetch_master.sv ====
`timescale 1ns/1ns

module ifu_fetch_master (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              fetch_req,
    input  logic [mem_pkg::ADDR_W-1:0]        fetch_addr,
    output logic                              fetch_ready,
    output logic                              fetch_valid,
    output logic [mem_pkg::DATA_W-1:0]        fetch_data,
    output logic                              fetch_last,
    output logic                              fetch_err,
    output logic [mem_pkg::ADDR_W-1:0]        araddr,
    output logic                              arvalid,
    output logic [axi_pkg::AXI_ID_W-1:0]      arid,
    output logic [axi_pkg::AXI_LEN_W-1:0]     arlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0]    arsize,
    output logic [axi_pkg::AXI_BURST_W-1:0]   arburst,
    output logic                              rready,
    input  logic                              arready,
    input  logic                              rvalid,
    input  logic [mem_pkg::DATA_W-1:0]        rdata,
    input  logic [axi_pkg::AXI_RESP_W-1:0]    rresp,
    input  logic                              rlast,
    input  logic [axi_pkg::AXI_ID_W-1:0]      rid
);
    import axi_pkg::*;
    import mem_pkg::*;

    localparam int OFF_W = $clog2(LINE_BEATS * STRB_W);  // byte offset inside a line.

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_t;

    state_t            state;
    logic [ADDR_W-1:0] line_addr;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (fetch_req) state <= S_ADDR;
                S_ADDR: if (arready) state <= S_DATA;
                S_DATA: if (rvalid && rlast) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_ready && fetch_req) begin
            line_addr <= {fetch_addr[ADDR_W-1:OFF_W], OFF_W'(0)};
        end
    end

    assign fetch_ready = (state == S_IDLE);

    assign araddr  = line_addr;
    assign arvalid = (state == S_ADDR);
    assign arid    = AXI_ID_W'(IFU_ID);
    assign arlen   = AXI_LEN_W'(LINE_BEATS - 1);
    assign arsize  = AXI_SIZE_WORD;
    assign arburst = AXI_BURST_INCR;
    assign rready  = 1'b1;

    // beats go straight out to the fetch port as they arrive.
    assign fetch_valid = rvalid && (state == S_DATA);
    assign fetch_data  = rdata;
    assign fetch_last  = rlast;
    assign fetch_err   = (rresp != AXI_RESP_OKAY);

    a_rid_match: assert property (@(posedge clock) disable iff (rst)
        rvalid |-> (rid == AXI_ID_W'(IFU_ID)));

endmodule

// ==== design/lsu_access_master.sv ====
`timescale 1ns/1ns

module lsu_access_master (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              lsu_req,
    input  logic                              lsu_we,
    input  logic [mem_pkg::ADDR_W-1:0]        lsu_addr,
    input  logic [mem_pkg::DATA_W-1:0]        lsu_wdata,
    input  logic [mem_pkg::STRB_W-1:0]        lsu_wstrb,
    output logic                              lsu_ready,
    output logic                              lsu_done,
    output logic [mem_pkg::DATA_W-1:0]        lsu_rdata,
    output logic                              lsu_err,
    output logic                              awvalid, wvalid, wlast, bready,
    output logic                              arvalid, rready,
    output logic [mem_pkg::ADDR_W-1:0]        awaddr, araddr,
    output logic [axi_pkg::AXI_ID_W-1:0]      awid, arid,
    output logic [axi_pkg::AXI_LEN_W-1:0]     awlen, arlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0]    awsize, arsize,
    output logic [axi_pkg::AXI_BURST_W-1:0]   awburst, arburst,
    output logic [mem_pkg::DATA_W-1:0]        wdata,
    output logic [mem_pkg::STRB_W-1:0]        wstrb,
    input  logic                              awready, wready, bvalid,
    input  logic                              arready, rvalid, rlast,
    input  logic [axi_pkg::AXI_RESP_W-1:0]    bresp, rresp,
    input  logic [axi_pkg::AXI_ID_W-1:0]      bid, rid,
    input  logic [mem_pkg::DATA_W-1:0]        rdata
);
    import axi_pkg::*;
    import mem_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_AW, S_W, S_B, S_AR, S_R} state_t;

    state_t            state;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] wstrb_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (lsu_req) state <= lsu_we ? S_AW : S_AR;
                S_AW:   if (awready) state <= S_W;   // the data beat waits for the address.
                S_W:    if (wready) state <= S_B;
                S_B:    if (bvalid) state <= S_IDLE;
                S_AR:   if (arready) state <= S_R;
                S_R:    if (rvalid && rlast) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (lsu_ready && lsu_req) begin
            addr_q  <= lsu_addr;
            wdata_q <= lsu_wdata;
            wstrb_q <= lsu_wstrb;
        end
    end

    assign lsu_ready = (state == S_IDLE);

    assign awvalid = (state == S_AW);
    assign awaddr  = addr_q;
    assign awid    = AXI_ID_W'(LSU_ID);
    assign awlen   = '0;                // single beat.
    assign awsize  = AXI_SIZE_WORD;
    assign awburst = AXI_BURST_INCR;
    assign wvalid  = (state == S_W);
    assign wdata   = wdata_q;
    assign wstrb   = wstrb_q;
    assign wlast   = 1'b1;
    assign bready  = 1'b1;

    assign arvalid = (state == S_AR);
    assign araddr  = addr_q;
    assign arid    = AXI_ID_W'(LSU_ID);
    assign arlen   = '0;
    assign arsize  = AXI_SIZE_WORD;
    assign arburst = AXI_BURST_INCR;
    assign rready  = 1'b1;

    // completion is flagged on the response cycle itself.
    assign lsu_done  = ((state == S_B) && bvalid) || ((state == S_R) && rvalid && rlast);
    assign lsu_err   = (state == S_B) ? (bresp != AXI_RESP_OKAY) : (rresp != AXI_RESP_OKAY);
    assign lsu_rdata = rdata;

    a_resp_id: assert property (@(posedge clock) disable iff (rst)
        (bvalid |-> bid == AXI_ID_W'(LSU_ID)) and (rvalid |-> rid == AXI_ID_W'(LSU_ID)));

endmodule

// ==== design/axi_sram.sv ====
`timescale 1ns/1ns

module axi_sram (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              awvalid, wvalid, wlast, bready,
    input  logic                              arvalid, rready,
    input  logic [mem_pkg::ADDR_W-1:0]        awaddr, araddr,
    input  logic [axi_pkg::AXI_ID_W-1:0]      awid, arid,
    input  logic [axi_pkg::AXI_LEN_W-1:0]     awlen, arlen,
    input  logic [axi_pkg::AXI_SIZE_W-1:0]    awsize, arsize,
    input  logic [axi_pkg::AXI_BURST_W-1:0]   awburst, arburst,
    input  logic [mem_pkg::DATA_W-1:0]        wdata,
    input  logic [mem_pkg::STRB_W-1:0]        wstrb,
    output logic                              awready, wready, bvalid,
    output logic                              arready, rvalid, rlast,
    output logic [axi_pkg::AXI_RESP_W-1:0]    bresp, rresp,
    output logic [axi_pkg::AXI_ID_W-1:0]      bid, rid,
    output logic [mem_pkg::DATA_W-1:0]        rdata
);
    import axi_pkg::*;
    import mem_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {S_IDLE, S_RD, S_WR, S_BRESP} state_t;

    state_t               state;
    logic [ADDR_W-3:0]    idx;      // word address of the current beat.
    logic [AXI_LEN_W-1:0] cnt;      // beats left after this one.
    logic [AXI_ID_W-1:0]  id_q;
    logic                 incr;
    logic                 size_ok;
    logic                 err;
    logic                 beat_ok;
    logic [DATA_W-1:0]    mem [MEM_WORDS];

    // only word-sized beats inside the array are served.
    assign beat_ok = size_ok && (idx < MEM_WORDS);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= S_IDLE;
            err   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (awvalid) begin
                        state <= S_WR;
                        err   <= 1'b0;
                    end else if (arvalid) begin
                        state <= S_RD;
                    end
                end
                S_RD: if (rready && cnt == '0) state <= S_IDLE;
                S_WR: begin
                    if (wvalid) begin
                        if (!beat_ok) err <= 1'b1;  // one bad beat spoils the response.
                        if (wlast || cnt == '0) state <= S_BRESP;
                    end
                end
                S_BRESP: if (bready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_IDLE) begin
            idx     <= awvalid ? awaddr[ADDR_W-1:2] : araddr[ADDR_W-1:2];
            cnt     <= awvalid ? awlen : arlen;
            id_q    <= awvalid ? awid : arid;
            incr    <= (awvalid ? awburst : arburst) == AXI_BURST_INCR;
            size_ok <= (awvalid ? awsize : arsize) == AXI_SIZE_WORD;
        end else if ((rvalid && rready) || (wvalid && wready)) begin
            if (incr) idx <= idx + 1'b1;
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wvalid && wready && beat_ok) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b]) mem[idx[IDX_W-1:0]][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    assign awready = (state == S_IDLE);
    assign arready = (state == S_IDLE) && !awvalid;  // a write wins a same-cycle tie.

    assign rvalid = (state == S_RD);
    assign rdata  = beat_ok ? mem[idx[IDX_W-1:0]] : '0;
    assign rresp  = beat_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    assign rlast  = (cnt == '0);
    assign rid    = id_q;

    assign wready = (state == S_WR);
    assign bvalid = (state == S_BRESP);
    assign bresp  = err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    assign bid    = id_q;

    // write data only shows up after the master's address was taken.
    a_w_after_aw: assert property (@(posedge clock) disable iff (rst)
        wvalid |-> (state == S_WR));

endmodule

// ==== design/mem_subsys_top.sv ====
`timescale 1ns/1ns

module mem_subsys_top (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         fetch_req,
    input  logic [mem_pkg::ADDR_W-1:0]   fetch_addr,
    output logic                         fetch_ready,
    output logic                         fetch_valid,
    output logic [mem_pkg::DATA_W-1:0]   fetch_data,
    output logic                         fetch_last,
    output logic                         fetch_err,
    input  logic                         lsu_req,
    input  logic                         lsu_we,
    input  logic [mem_pkg::ADDR_W-1:0]   lsu_addr,
    input  logic [mem_pkg::DATA_W-1:0]   lsu_wdata,
    input  logic [mem_pkg::STRB_W-1:0]   lsu_wstrb,
    output logic                         lsu_ready,
    output logic                         lsu_done,
    output logic [mem_pkg::DATA_W-1:0]   lsu_rdata,
    output logic                         lsu_err
);
    import axi_pkg::*;
    import mem_pkg::*;

    // fetch master to arbiter.
    logic                   ifu_arvalid, ifu_arready, ifu_rready, ifu_rvalid, ifu_rlast;
    logic [ADDR_W-1:0]      ifu_araddr;
    logic [AXI_ID_W-1:0]    ifu_arid, ifu_rid;
    logic [AXI_LEN_W-1:0]   ifu_arlen;
    logic [AXI_SIZE_W-1:0]  ifu_arsize;
    logic [AXI_BURST_W-1:0] ifu_arburst;
    logic [DATA_W-1:0]      ifu_rdata;
    logic [AXI_RESP_W-1:0]  ifu_rresp;

    // load/store master to arbiter; the w data and r data carry a suffix to stay
    // apart from the request ports of the same name.
    logic                   lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_wlast;
    logic                   lsu_bvalid, lsu_bready, lsu_arvalid, lsu_arready;
    logic                   lsu_rvalid, lsu_rready, lsu_rlast;
    logic [ADDR_W-1:0]      lsu_awaddr, lsu_araddr;
    logic [AXI_ID_W-1:0]    lsu_awid, lsu_arid, lsu_bid, lsu_rid;
    logic [AXI_LEN_W-1:0]   lsu_awlen, lsu_arlen;
    logic [AXI_SIZE_W-1:0]  lsu_awsize, lsu_arsize;
    logic [AXI_BURST_W-1:0] lsu_awburst, lsu_arburst;
    logic [DATA_W-1:0]      lsu_wdata_bus, lsu_rdata_bus;
    logic [STRB_W-1:0]      lsu_wstrb_bus;
    logic [AXI_RESP_W-1:0]  lsu_bresp, lsu_rresp;

    // arbiter to sram.
    logic                   awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic                   arvalid, arready, rvalid, rready, rlast;
    logic [ADDR_W-1:0]      awaddr, araddr;
    logic [AXI_ID_W-1:0]    awid, arid, bid, rid;
    logic [AXI_LEN_W-1:0]   awlen, arlen;
    logic [AXI_SIZE_W-1:0]  awsize, arsize;
    logic [AXI_BURST_W-1:0] awburst, arburst;
    logic [DATA_W-1:0]      wdata, rdata;
    logic [STRB_W-1:0]      wstrb;
    logic [AXI_RESP_W-1:0]  bresp, rresp;

    ifu_fetch_master i_ifu (
        .clock, .rst, .fetch_req, .fetch_addr, .fetch_ready,
        .fetch_valid, .fetch_data, .fetch_last, .fetch_err,
        .araddr(ifu_araddr), .arvalid(ifu_arvalid), .arid(ifu_arid),
        .arlen(ifu_arlen), .arsize(ifu_arsize), .arburst(ifu_arburst),
        .rready(ifu_rready), .arready(ifu_arready), .rvalid(ifu_rvalid),
        .rdata(ifu_rdata), .rresp(ifu_rresp), .rlast(ifu_rlast), .rid(ifu_rid)
    );

    lsu_access_master i_lsu (
        .clock, .rst, .lsu_req, .lsu_we, .lsu_addr, .lsu_wdata, .lsu_wstrb,
        .lsu_ready, .lsu_done, .lsu_rdata, .lsu_err,
        .awvalid(lsu_awvalid), .awaddr(lsu_awaddr), .awid(lsu_awid),
        .awlen(lsu_awlen), .awsize(lsu_awsize), .awburst(lsu_awburst),
        .awready(lsu_awready), .wvalid(lsu_wvalid), .wdata(lsu_wdata_bus),
        .wstrb(lsu_wstrb_bus), .wlast(lsu_wlast), .wready(lsu_wready),
        .bvalid(lsu_bvalid), .bready(lsu_bready), .bresp(lsu_bresp), .bid(lsu_bid),
        .arvalid(lsu_arvalid), .araddr(lsu_araddr), .arid(lsu_arid),
        .arlen(lsu_arlen), .arsize(lsu_arsize), .arburst(lsu_arburst),
        .arready(lsu_arready), .rvalid(lsu_rvalid), .rready(lsu_rready),
        .rdata(lsu_rdata_bus), .rresp(lsu_rresp), .rlast(lsu_rlast), .rid(lsu_rid)
    );

    axi_arbiter i_arb (
        .*,
        .lsu_wdata(lsu_wdata_bus),
        .lsu_wstrb(lsu_wstrb_bus),
        .lsu_rdata(lsu_rdata_bus)
    );

    axi_sram i_sram (.*);

endmodule

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/1ns

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int NUM_TESTS = 16;
    localparam int IDX_W     = $clog2(MEM_WORDS);
    localparam int LINE_B    = LINE_BEATS * STRB_W;     // bytes per fetch line.

    typedef enum logic [2:0] {OP_IDLE, OP_STORE, OP_LOAD, OP_FETCH, OP_PAIR, OP_ST_FETCH} op_t;

    logic              clock;
    logic              rst;
    logic              fetch_req;
    logic [ADDR_W-1:0] fetch_addr;
    logic              fetch_ready;
    logic              fetch_valid;
    logic [DATA_W-1:0] fetch_data;
    logic              fetch_last;
    logic              fetch_err;
    logic              lsu_req;
    logic              lsu_we;
    logic [ADDR_W-1:0] lsu_addr;
    logic [DATA_W-1:0] lsu_wdata;
    logic [STRB_W-1:0] lsu_wstrb;
    logic              lsu_ready;
    logic              lsu_done;
    logic [DATA_W-1:0] lsu_rdata;
    logic              lsu_err;

    logic [DATA_W-1:0] ref_mem [MEM_WORDS];   // what the sram should hold.
    logic [15:0]       lfsr;
    int                test_errs;
    int                pass_count;
    int                fail_count;
    time               lsu_done_at;
    time               fetch_first_at;

    // stimulus table, filled once before the run.
    op_t               t_op    [NUM_TESTS];
    logic [ADDR_W-1:0] t_addr  [NUM_TESTS];
    logic [ADDR_W-1:0] t_addr2 [NUM_TESTS];
    logic [DATA_W-1:0] t_data  [NUM_TESTS];
    logic [STRB_W-1:0] t_strb  [NUM_TESTS];
    logic              t_rnd   [NUM_TESTS];
    string             t_name  [NUM_TESTS];
    int                n_entries;

    mem_subsys_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output logic [DATA_W-1:0] w);
        w = '0;
        for (int k = 0; k < DATA_W; k++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[DATA_W-2:0], lfsr[0]};
        end
    endtask

    task automatic ref_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic err);
        err  = (addr >= ADDR_W'(MEM_WORDS * STRB_W));
        data = err ? '0 : ref_mem[addr[IDX_W+1:2]];
    endtask

    task automatic ref_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
        if (addr < ADDR_W'(MEM_WORDS * STRB_W)) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) ref_mem[addr[IDX_W+1:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic check_idle(input string name);
        repeat (5) begin
            @(negedge clock);
            check({name, " fetch_valid"}, 32'd0, 32'(fetch_valid));
            check({name, " lsu_done"}, 32'd0, 32'(lsu_done));
            check({name, " fetch_ready"}, 32'd1, 32'(fetch_ready));
            check({name, " lsu_ready"}, 32'd1, 32'(lsu_ready));
        end
    endtask

    task automatic run_lsu(input string name, input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] exp_data;
        logic              exp_err;
        if (we) ref_write(addr, data, strb);   // the model takes the store when it is issued.
        ref_read(addr, exp_data, exp_err);
        @(posedge clock);
        lsu_req   <= 1'b1;
        lsu_we    <= we;
        lsu_addr  <= addr;
        lsu_wdata <= data;
        lsu_wstrb <= strb;
        do @(negedge clock); while (!lsu_ready);
        @(posedge clock);
        lsu_req <= 1'b0;
        do @(negedge clock); while (!lsu_done);
        lsu_done_at = $time;
        check({name, " lsu_err"}, 32'(exp_err), 32'(lsu_err));
        if (!we) check({name, " lsu_rdata"}, exp_data, lsu_rdata);
    endtask

    task automatic run_fetch(input string name, input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] base;
        logic [DATA_W-1:0] exp_data;
        logic              exp_err;
        base = addr & ~ADDR_W'(LINE_B - 1);    // low bits of the request are ignored.
        @(posedge clock);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        do @(negedge clock); while (!fetch_ready);
        @(posedge clock);
        fetch_req <= 1'b0;
        for (int beat = 0; beat < LINE_BEATS; beat++) begin
            do @(negedge clock); while (!fetch_valid);
            if (beat == 0) fetch_first_at = $time;
            ref_read(base + ADDR_W'(beat * STRB_W), exp_data, exp_err);
            check({name, " fetch_data"}, exp_data, fetch_data);
            check({name, " fetch_err"}, 32'(exp_err), 32'(fetch_err));
            check({name, " fetch_last"}, 32'(beat == LINE_BEATS - 1), 32'(fetch_last));
        end
    endtask

    // the load/store side holds the bus first, so its response comes before any fetch beat.
    task automatic check_order(input string name);
        if (lsu_done_at >= fetch_first_at) begin
            $display("%s: a fetch beat arrived before lsu_done, so the grant order is wrong",
                     name);
            test_errs++;
        end
    endtask

    task automatic add_entry(input op_t op, input logic [ADDR_W-1:0] addr,
                             input logic [ADDR_W-1:0] addr2, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb, input logic rnd, input string name);
        t_op[n_entries]    = op;
        t_addr[n_entries]  = addr;
        t_addr2[n_entries] = addr2;
        t_data[n_entries]  = data;
        t_strb[n_entries]  = strb;
        t_rnd[n_entries]   = rnd;
        t_name[n_entries]  = name;
        n_entries++;
    endtask

    // for a pair addr is the fetch and addr2 the load; for a store with fetch it is the other
    // way round.
    task automatic fill_table();
        add_entry(OP_IDLE,     32'h000, 32'h000, 32'h0,        4'h0, 1'b0, "idle_after_reset");
        add_entry(OP_STORE,    32'h000, 32'h000, 32'h11223344, 4'hf, 1'b0, "store_word0");
        add_entry(OP_STORE,    32'h010, 32'h000, 32'h0,        4'hf, 1'b1, "fill_line_w0");
        add_entry(OP_STORE,    32'h014, 32'h000, 32'h0,        4'hf, 1'b1, "fill_line_w1");
        add_entry(OP_STORE,    32'h018, 32'h000, 32'h0,        4'hf, 1'b1, "fill_line_w2");
        add_entry(OP_STORE,    32'h01c, 32'h000, 32'h0,        4'hf, 1'b1, "fill_line_w3");
        add_entry(OP_STORE,    32'h000, 32'h000, 32'haabbccdd, 4'h5, 1'b0, "partial_store");
        add_entry(OP_LOAD,     32'h000, 32'h000, 32'h0,        4'h0, 1'b0, "merged_load");
        add_entry(OP_FETCH,    32'h010, 32'h000, 32'h0,        4'h0, 1'b0, "line_fetch");
        add_entry(OP_LOAD,     32'h400, 32'h000, 32'h0,        4'h0, 1'b0, "oob_load");
        add_entry(OP_STORE,    32'h400, 32'h000, 32'hdeadbeef, 4'hf, 1'b0, "oob_store");
        add_entry(OP_LOAD,     32'h000, 32'h000, 32'h0,        4'h0, 1'b0, "word0_unchanged");
        add_entry(OP_FETCH,    32'h400, 32'h000, 32'h0,        4'h0, 1'b0, "oob_fetch");
        add_entry(OP_PAIR,     32'h01c, 32'h014, 32'h0,        4'h0, 1'b0, "fetch_load_tie");
        add_entry(OP_ST_FETCH, 32'h018, 32'h010, 32'hcafef00d, 4'hf, 1'b0, "fetch_during_store");
        add_entry(OP_LOAD,     32'h018, 32'h000, 32'h0,        4'h0, 1'b0, "load_after_handover");
    endtask

    initial begin
        repeat (NUM_TESTS * 100) @(posedge clock);
        $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * 100);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [DATA_W-1:0] data;
        rst        <= 1'b1;
        fetch_req  <= 1'b0;
        fetch_addr <= '0;
        lsu_req    <= 1'b0;
        lsu_we     <= 1'b0;
        lsu_addr   <= '0;
        lsu_wdata  <= '0;
        lsu_wstrb  <= '0;
        lfsr           = 16'd13403;
        pass_count     = 0;
        fail_count     = 0;
        lsu_done_at    = 0;
        fetch_first_at = 0;
        n_entries      = 0;
        fill_table();
        repeat (3) @(posedge clock);
        rst <= 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            test_errs = 0;
            data = t_data[i];
            if (t_rnd[i]) random_word(data);
            case (t_op[i])
                OP_IDLE:  check_idle(t_name[i]);
                OP_STORE: run_lsu(t_name[i], 1'b1, t_addr[i], data, t_strb[i]);
                OP_LOAD:  run_lsu(t_name[i], 1'b0, t_addr[i], data, t_strb[i]);
                OP_FETCH: run_fetch(t_name[i], t_addr[i]);
                OP_PAIR: begin
                    fork
                        run_fetch(t_name[i], t_addr[i]);
                        run_lsu(t_name[i], 1'b0, t_addr2[i], data, t_strb[i]);
                    join
                    check_order(t_name[i]);
                end
                OP_ST_FETCH: begin
                    fork
                        run_lsu(t_name[i], 1'b1, t_addr[i], data, t_strb[i]);
                        begin
                            repeat (2) @(posedge clock);   // the store owns the bus by now.
                            run_fetch(t_name[i], t_addr2[i]);
                        end
                    join
                    check_order(t_name[i]);
                end
                default: ;
            endcase
            if (test_errs == 0) begin
                pass_count++;
                $display("test %s ok", t_name[i]);
            end else begin
                fail_count++;
                $display("test %s had %0d mismatches", t_name[i], test_errs);
            end
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== mem_subsys.f ====
common/axi_pkg.sv
common/mem_pkg.sv
arbiter/axi_arbiter.sv
design/ifu_fetch_master.sv
design/lsu_access_master.sv
design/axi_sram.sv
design/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_subsys.f --top-module tb_mem_subsys -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F 'Test failures found' sim.log; then
    exit 1
fi
if ! grep -q -F 'All tests passed!' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
